// ==== source/av_pkg.sv ====
`default_nettype none

package av_pkg;

    // Audio path
    localparam int SAMPLE_W  = 16;           // Signed PCM sample
    localparam int DAC_ACC_W = SAMPLE_W + 1; // One carry bit on top of the sample

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Video path
    localparam int GAME_COLOR_W = 4;  // Native core colour depth
    localparam int VGA_COLOR_W  = 6;  // Board DAC colour depth

    typedef logic [GAME_COLOR_W-1:0] game_color_t;
    typedef logic [VGA_COLOR_W-1:0]  vga_color_t;

    // Status word seen by the core
    localparam int STATUS_W     = 32;
    localparam int SCANLINE_LSB = 3;  // Scanline intensity field
    localparam int SCANLINE_W   = 3;

    typedef logic [STATUS_W-1:0] status_t;

endpackage

`default_nettype wire

// ==== source/load_pkg.sv ====
`default_nettype none

package load_pkg;

    // SPI flash READ command and where the ROM image starts
    localparam logic [7:0]  FLASH_READ_CMD = 8'h03;
    localparam logic [23:0] ROM_BASE       = 24'h000000;
    localparam int          CMD_BITS       = $bits(FLASH_READ_CMD) + $bits(ROM_BASE);

    localparam int ROM_BYTES = 32;  // Image size in bytes

    // SPI clock is clk_sys / (2 * SPI_HALF)
    localparam int SPI_HALF = 2;
    localparam int DIV_W    = $clog2(SPI_HALF) + 1;

    localparam int BIT_CNT_W  = $clog2(CMD_BITS);  // Also wide enough for a data byte
    localparam int BYTE_CNT_W = $clog2(ROM_BYTES);

    typedef logic [21:0] rom_addr_t;  // Wishbone byte address
    typedef logic [7:0]  rom_byte_t;

    typedef enum logic [2:0] {
        IDLE,  // Out of reset, flash deselected
        CMD,   // Opcode and address going out
        DATA,  // Shifting in one byte
        HOLD,  // Byte offered, clock stopped
        DONE   // Image loaded
    } reader_state_t;

endpackage

`default_nettype wire

// ==== source/sigma_delta_dac.sv ====
`timescale 1ns/1ps
`default_nettype none

module sigma_delta_dac (
    input  wire logic             clk_sys,
    input  wire logic             rst,
    input  wire av_pkg::sample_t  sample,
    output logic                  pwm
);

    import av_pkg::*;

    logic [SAMPLE_W-1:0]  u;    // Offset binary sample
    logic [DAC_ACC_W-1:0] acc;  // Carry lives in the top bit

    // Flip the sign bit, so -32768 maps to 0 and +32767 to 65535
    assign u = {~sample[SAMPLE_W-1], sample[SAMPLE_W-2:0]};

    // First-order loop
    // The carry is dropped back out each cycle and forms the bit stream
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            acc <= '0;
        end else begin
            acc <= {1'b0, acc[DAC_ACC_W-2:0]} + {1'b0, u};  // Keep residue, add sample
        end
    end

    assign pwm = acc[DAC_ACC_W-1];  // Density of ones is u / 2^16

endmodule

`default_nettype wire

// ==== source/spi_flash_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_flash_reader (
    input  wire logic                clk_sys,
    input  wire logic                rst,
    output logic                     sd_cs_n,
    output logic                     sd_clk,
    output logic                     sd_mosi,
    input  wire logic                sd_miso,
    output load_pkg::rom_byte_t      byte_data,
    output logic                     byte_valid,
    input  wire logic                byte_ready,
    output logic                     last
);

    import load_pkg::*;

    reader_state_t         state;
    logic [DIV_W-1:0]      div_cnt;   // Half-period divider
    logic [BIT_CNT_W-1:0]  bit_cnt;   // Bit within command or byte
    logic [BYTE_CNT_W-1:0] byte_cnt;  // Bytes handed over so far
    logic [CMD_BITS-1:0]   cmd_sr;    // Opcode and address, MSB first
    logic                  clk_run;
    logic                  tick;
    logic                  rise;
    logic                  fall;

    assign clk_run = (state == CMD) || (state == DATA);  // SPI clock only toggles here
    assign tick    = clk_run && (div_cnt == DIV_W'(SPI_HALF - 1));
    assign rise    = tick && !sd_clk;  // sd_clk about to go high
    assign fall    = tick && sd_clk;   // sd_clk about to go low

    assign sd_mosi = cmd_sr[CMD_BITS-1];
    assign last    = byte_valid && (byte_cnt == BYTE_CNT_W'(ROM_BYTES - 1));

    // Divider restarts whenever the clock is parked,
    // so every byte takes the same number of cycles
    always_ff @(posedge clk_sys) begin
        if (rst || !clk_run) begin
            div_cnt <= '0;
        end else if (tick) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            state      <= IDLE;
            sd_cs_n    <= 1'b1;
            sd_clk     <= 1'b0;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            byte_valid <= 1'b0;
        end else begin
            if (tick) begin
                sd_clk <= ~sd_clk;
            end
            case (state)
                IDLE: begin
                    sd_cs_n <= 1'b0;  // Select flash, first bit already on MOSI
                    bit_cnt <= '0;
                    state   <= CMD;
                end
                CMD: begin
                    if (fall) begin
                        if (bit_cnt == BIT_CNT_W'(CMD_BITS - 1)) begin
                            bit_cnt <= '0;
                            state   <= DATA;  // Flash starts streaming now
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                DATA: begin
                    if (fall) begin
                        if (bit_cnt == BIT_CNT_W'($bits(rom_byte_t) - 1)) begin
                            bit_cnt    <= '0;
                            byte_valid <= 1'b1;
                            state      <= HOLD;  // Clock parks low here
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                HOLD: begin
                    if (byte_ready) begin
                        byte_valid <= 1'b0;
                        if (last) begin
                            sd_cs_n <= 1'b1;  // Release flash for good
                            state   <= DONE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= DATA;
                        end
                    end
                end
                default: begin
                    // DONE waits for the next reset
                end
            endcase
        end
    end

    // Shifters
    always_ff @(posedge clk_sys) begin
        if (state == IDLE) begin
            cmd_sr <= {FLASH_READ_CMD, ROM_BASE};
        end else if (state == CMD && fall) begin
            cmd_sr <= {cmd_sr[CMD_BITS-2:0], 1'b0};  // Next bit out on falling edge
        end
        if (state == DATA && rise) begin
            byte_data <= {byte_data[$bits(rom_byte_t)-2:0], sd_miso};  // Sample on rising edge
        end
    end

endmodule

`default_nettype wire

// ==== source/rom_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom_loader (
    input  wire logic                clk_sys,
    input  wire logic                rst,
    output logic                     sd_cs_n,
    output logic                     sd_clk,
    output logic                     sd_mosi,
    input  wire logic                sd_miso,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output load_pkg::rom_addr_t      wb_adr,
    output load_pkg::rom_byte_t      wb_dat,
    input  wire logic                wb_ack,
    output logic                     downloading
);

    import load_pkg::*;

    rom_byte_t byte_data;
    logic      byte_valid;
    logic      byte_ready;  // One-cycle pulse after each ack
    logic      last;

    spi_flash_reader reader_inst (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .sd_cs_n    (sd_cs_n),
        .sd_clk     (sd_clk),
        .sd_mosi    (sd_mosi),
        .sd_miso    (sd_miso),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .byte_ready (byte_ready),
        .last       (last)
    );

    // One classic write per byte
    // valid is still high during the ready pulse, hence the guard
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            wb_cyc      <= 1'b0;
            wb_stb      <= 1'b0;
            wb_we       <= 1'b0;
            wb_adr      <= '0;   // Byte index into ROM
            byte_ready  <= 1'b0;
            downloading <= 1'b1; // Core held off until image is in
        end else begin
            byte_ready <= 1'b0;
            if (wb_cyc) begin
                if (wb_ack) begin
                    wb_cyc     <= 1'b0;
                    wb_stb     <= 1'b0;
                    wb_we      <= 1'b0;
                    wb_adr     <= wb_adr + 1'b1;
                    byte_ready <= 1'b1;  // Release the reader
                    if (last) begin
                        downloading <= 1'b0;
                    end
                end
            end else if (byte_valid && !byte_ready) begin
                wb_cyc <= 1'b1;
                wb_stb <= 1'b1;
                wb_we  <= 1'b1;
            end
        end
    end

    // Write data captured with the request
    always_ff @(posedge clk_sys) begin
        if (!wb_cyc && byte_valid) begin
            wb_dat <= byte_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/video_route.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_route (
    input  wire logic                 clk_sys,
    input  wire logic                 rst,
    input  wire av_pkg::game_color_t  game_r,
    input  wire av_pkg::game_color_t  game_g,
    input  wire av_pkg::game_color_t  game_b,
    input  wire logic                 hs,
    input  wire logic                 vs,
    input  wire av_pkg::vga_color_t   scan2x_r,
    input  wire av_pkg::vga_color_t   scan2x_g,
    input  wire av_pkg::vga_color_t   scan2x_b,
    input  wire logic                 scan2x_hs,
    input  wire logic                 scan2x_vs,
    input  wire logic [3:0]           vgactrl_en,
    input  wire logic [1:0]           videoconf,
    output logic                      scan2x_enb,
    output av_pkg::vga_color_t        video_r,
    output av_pkg::vga_color_t        video_g,
    output av_pkg::vga_color_t        video_b,
    output logic                      video_hs,
    output logic                      video_vs,
    output av_pkg::status_t           status
);

    import av_pkg::*;

    localparam int PAD_W = VGA_COLOR_W - GAME_COLOR_W;  // Zero LSBs below game colour

    logic    enb_c;  // Native 15 kHz mode
    logic    hsync;
    logic    vsync;
    logic    csync;
    status_t status_c;

    // BIOS setting XNOR scroll-lock toggle
    assign enb_c = ~(videoconf[0] ^ vgactrl_en[0]);

    assign hsync = enb_c ? ~hs : scan2x_hs;
    assign vsync = enb_c ? ~vs : scan2x_vs;
    assign csync = ~(hsync ^ vsync);  // SCART composite sync

    // Scanline level steps with the hotkey, BIOS bit sets the start
    always_comb begin
        status_c = '0;
        status_c[SCANLINE_LSB +: SCANLINE_W] = vgactrl_en[3:1] + SCANLINE_W'(videoconf[1]);
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            scan2x_enb <= 1'b0;
            video_r    <= '0;
            video_g    <= '0;
            video_b    <= '0;
            video_hs   <= 1'b0;
            video_vs   <= 1'b0;
            status     <= '0;
        end else begin
            scan2x_enb <= enb_c;
            video_r    <= enb_c ? {game_r, {PAD_W{1'b0}}} : scan2x_r;
            video_g    <= enb_c ? {game_g, {PAD_W{1'b0}}} : scan2x_g;
            video_b    <= enb_c ? {game_b, {PAD_W{1'b0}}} : scan2x_b;
            video_hs   <= enb_c ? csync : hsync;
            video_vs   <= enb_c ? 1'b1 : vsync;  // VS high puts the TV in RGB mode
            status     <= status_c;
        end
    end

endmodule

`default_nettype wire

// ==== source/zxdos_base.sv ====
`timescale 1ns/1ps
`default_nettype none

module zxdos_base (
    input  wire logic                 clk_sys,
    input  wire logic                 rst,
    // SPI flash
    output logic                      sd_cs_n,
    output logic                      sd_clk,
    output logic                      sd_mosi,
    input  wire logic                 sd_miso,
    // ROM write port
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output load_pkg::rom_addr_t       wb_adr,
    output load_pkg::rom_byte_t       wb_dat,
    input  wire logic                 wb_ack,
    output logic                      downloading,
    // Native video
    input  wire av_pkg::game_color_t  game_r,
    input  wire av_pkg::game_color_t  game_g,
    input  wire av_pkg::game_color_t  game_b,
    input  wire logic                 hs,
    input  wire logic                 vs,
    // Scan doubler video
    input  wire av_pkg::vga_color_t   scan2x_r,
    input  wire av_pkg::vga_color_t   scan2x_g,
    input  wire av_pkg::vga_color_t   scan2x_b,
    input  wire logic                 scan2x_hs,
    input  wire logic                 scan2x_vs,
    input  wire logic [3:0]           vgactrl_en,
    input  wire logic [1:0]           videoconf,
    output logic                      scan2x_enb,
    // VGA pins
    output av_pkg::vga_color_t        video_r,
    output av_pkg::vga_color_t        video_g,
    output av_pkg::vga_color_t        video_b,
    output logic                      video_hs,
    output logic                      video_vs,
    output av_pkg::status_t           status,
    // Sound
    input  wire av_pkg::sample_t      snd_left,
    input  wire av_pkg::sample_t      snd_right,
    output logic                      snd_pwm_l,
    output logic                      snd_pwm_r
);

    rom_loader loader_inst (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .sd_cs_n     (sd_cs_n),
        .sd_clk      (sd_clk),
        .sd_mosi     (sd_mosi),
        .sd_miso     (sd_miso),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat      (wb_dat),
        .wb_ack      (wb_ack),
        .downloading (downloading)
    );

    // Stereo always, one modulator per channel
    sigma_delta_dac dac_l (
        .clk_sys (clk_sys),
        .rst     (rst),
        .sample  (snd_left),
        .pwm     (snd_pwm_l)
    );

    sigma_delta_dac dac_r (
        .clk_sys (clk_sys),
        .rst     (rst),
        .sample  (snd_right),
        .pwm     (snd_pwm_r)
    );

    video_route video_inst (
        .clk_sys    (clk_sys),
        .rst        (rst),
        .game_r     (game_r),
        .game_g     (game_g),
        .game_b     (game_b),
        .hs         (hs),
        .vs         (vs),
        .scan2x_r   (scan2x_r),
        .scan2x_g   (scan2x_g),
        .scan2x_b   (scan2x_b),
        .scan2x_hs  (scan2x_hs),
        .scan2x_vs  (scan2x_vs),
        .vgactrl_en (vgactrl_en),
        .videoconf  (videoconf),
        .scan2x_enb (scan2x_enb),
        .video_r    (video_r),
        .video_g    (video_g),
        .video_b    (video_b),
        .video_hs   (video_hs),
        .video_vs   (video_vs),
        .status     (status)
    );

endmodule

`default_nettype wire

// ==== verif/spi_flash_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module spi_flash_model (
    input  wire logic clk_sys,
    input  wire logic sd_cs_n,
    input  wire logic sd_clk,
    input  wire logic sd_mosi,
    output logic      sd_miso,
    output logic      cmd_seen,
    output int        errors
);

    import load_pkg::*;

    logic [CMD_BITS-1:0] cmd_sr;   // Opcode then address, MSB first
    logic [23:0]         rx_addr;
    rom_byte_t           out_byte;
    int                  rx_bits;  // MOSI bits taken so far
    int                  tx_bits;  // MISO bits put out so far

    // Image content for flash byte address a
    function automatic rom_byte_t flash_byte(input int addr);
        return rom_byte_t'(addr * 37 + 5);
    endfunction

    initial begin
        sd_miso  = 1'b0;
        cmd_seen = 1'b0;
        errors   = 0;
        rx_bits  = 0;
        tx_bits  = 0;
    end

    // Mode 0, MOSI sampled on the rising edge
    always @(posedge sd_clk) begin
        if (!sd_cs_n && rx_bits < CMD_BITS) begin
            cmd_sr = {cmd_sr[CMD_BITS-2:0], sd_mosi};
            rx_bits++;
            if (rx_bits == CMD_BITS) begin
                cmd_seen = 1'b1;
                rx_addr  = cmd_sr[23:0];
                assert (cmd_sr[CMD_BITS-1 -: 8] == FLASH_READ_CMD) else begin
                    $display("CHECK FAILED flash opcode: expected %h, got %h",
                             FLASH_READ_CMD, cmd_sr[CMD_BITS-1 -: 8]);
                    errors++;
                end
                assert (rx_addr == ROM_BASE) else begin
                    $display("CHECK FAILED flash address: expected %h, got %h",
                             ROM_BASE, rx_addr);
                    errors++;
                end
            end
        end
    end

    // Data out on the falling edge, first bit right after the last address bit
    always @(negedge sd_clk) begin
        if (!sd_cs_n && rx_bits == CMD_BITS) begin
            out_byte = flash_byte(int'(rx_addr) + tx_bits / 8);
            sd_miso <= out_byte[7 - tx_bits % 8];
            tx_bits++;
        end
    end

    // Clock must be parked low while deselected
    assert property (@(posedge clk_sys) sd_cs_n |-> !sd_clk) else begin
        $display("SPI clock was high while the flash was deselected");
        errors++;
    end

endmodule

`default_nettype wire

// ==== verif/tb_zxdos_base.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_zxdos_base;

    import load_pkg::*;
    import av_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;  // Load ~1.5k, DAC ~3.1k, video < 100
    localparam int DAC_WINDOW     = 1024;
    localparam int VIDEO_ROUNDS   = 16;

    logic        clk_sys;
    logic        rst;
    logic        sd_cs_n, sd_clk, sd_mosi, sd_miso;
    logic        wb_cyc, wb_stb, wb_we, wb_ack, downloading;
    rom_addr_t   wb_adr;
    rom_byte_t   wb_dat;
    game_color_t game_r, game_g, game_b;
    logic        hs, vs, scan2x_hs, scan2x_vs;
    vga_color_t  scan2x_r, scan2x_g, scan2x_b;
    logic [3:0]  vgactrl_en;
    logic [1:0]  videoconf;
    logic        scan2x_enb, video_hs, video_vs;
    vga_color_t  video_r, video_g, video_b;
    status_t     status;
    sample_t     snd_left, snd_right;
    logic        snd_pwm_l, snd_pwm_r;

    logic        cmd_seen;
    int          flash_errors;
    int          errors;
    int          write_count;        // Acks given by the slave
    int          cycle_count;
    int          tests_passed;
    int          tests_failed;
    int          test_start_errors;
    logic [31:0] lcg_state;

    zxdos_base zxdos_base_inst (.*);

    spi_flash_model flash_inst (
        .clk_sys  (clk_sys),
        .sd_cs_n  (sd_cs_n),
        .sd_clk   (sd_clk),
        .sd_mosi  (sd_mosi),
        .sd_miso  (sd_miso),
        .cmd_seen (cmd_seen),
        .errors   (flash_errors)
    );

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;  // 250 MHz
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {8'h00, lcg_state[31:8]};  // Low LCG bits have short periods
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_density(input string name, input sample_t smp, input int ones);
        int u;
        int expected;
        u        = int'({~smp[15], smp[14:0]});  // Offset binary
        expected = u * DAC_WINDOW / 65536;
        assert (ones >= expected - 1 && ones <= expected + 1) else begin
            $display("CHECK FAILED %s: expected %h ones (+-1), got %h", name, expected, ones);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int new_errors;
        new_errors = errors + flash_errors - test_start_errors;
        if (new_errors == 0) begin
            $display("PASS  %s", name);
            tests_passed++;
        end else begin
            $display("FAIL  %s, %0d errors", name, new_errors);
            tests_failed++;
        end
        test_start_errors = errors + flash_errors;
    endtask

    // field holds vgactrl_en[3:1] over videoconf[1]
    task automatic drive_video(input logic native, input logic [3:0] field);
        logic [31:0] r;
        r          = next_random();
        game_r     = r[3:0];
        game_g     = r[7:4];
        game_b     = r[11:8];
        hs         = r[12];
        vs         = r[13];
        scan2x_hs  = r[14];
        scan2x_vs  = r[15];
        vgactrl_en = {field[3:1], r[16]};
        videoconf  = {field[0], native ? r[16] : ~r[16]};  // Equal bits pick native
        r          = next_random();
        scan2x_r   = r[5:0];
        scan2x_g   = r[11:6];
        scan2x_b   = r[17:12];
    endtask

    task automatic check_video(input logic native, input logic [3:0] field);
        logic        exp_csync;
        logic [31:0] exp_status;
        exp_csync  = ~(~hs ^ ~vs);  // XNOR of the active-high syncs
        exp_status = ((int'(field[3:1]) + int'(field[0])) % 8) << SCANLINE_LSB;
        check_value("scan2x_enb", native, scan2x_enb);
        check_value("status", exp_status, status);
        if (native) begin
            check_value("video_r", {game_r, 2'b00}, video_r);
            check_value("video_g", {game_g, 2'b00}, video_g);
            check_value("video_b", {game_b, 2'b00}, video_b);
            check_value("video_hs", exp_csync, video_hs);
            check_value("video_vs", 1, video_vs);
        end else begin
            check_value("video_r", scan2x_r, video_r);
            check_value("video_g", scan2x_g, video_g);
            check_value("video_b", scan2x_b, video_b);
            check_value("video_hs", scan2x_hs, video_hs);
            check_value("video_vs", scan2x_vs, video_vs);
        end
    endtask

    // Request must hold still until acked
    assert property (@(posedge clk_sys) disable iff (rst)
        (wb_cyc && !wb_ack) |=> (wb_cyc && wb_stb && wb_we && $stable(wb_adr)
                                  && $stable(wb_dat)))
    else begin
        $display("Wishbone request changed before its ack at address %h", wb_adr);
        errors++;
    end

    // Load ends in the cycle after the final ack
    assert property (@(posedge clk_sys) disable iff (rst)
        $fell(downloading) |-> ($past(wb_ack) && write_count == ROM_BYTES))
    else begin
        $display("downloading fell at the wrong time, after %0d writes", write_count);
        errors++;
    end

    // ROM memory with 0 to 7 wait cycles per write
    initial begin : wb_slave
        int delay;
        write_count = 0;
        forever begin
            @(posedge clk_sys);
            #1;
            if (wb_cyc && wb_stb) begin
                delay = next_random() % 8;
                repeat (delay) begin
                    @(posedge clk_sys);
                    #1;
                end
                check_value("wb_we", 1, wb_we);
                check_value("wb_adr", write_count, wb_adr);
                check_value("wb_dat", (write_count * 37 + 5) & 8'hff, wb_dat);
                wb_ack = 1'b1;
                write_count++;
                @(posedge clk_sys);
                #1;
                wb_ack = 1'b0;
            end
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_sys);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [31:0] r;
        int          ones_l;
        int          ones_r;
        lcg_state         = 32'd6;
        errors            = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        test_start_errors = 0;
        rst               = 1'b1;
        wb_ack            = 1'b0;
        game_r            = '0;
        game_g            = '0;
        game_b            = '0;
        hs                = 1'b0;
        vs                = 1'b0;
        scan2x_r          = '0;
        scan2x_g          = '0;
        scan2x_b          = '0;
        scan2x_hs         = 1'b0;
        scan2x_vs         = 1'b0;
        vgactrl_en        = 4'b0010;  // Scanline field of 1 held off by reset
        videoconf         = '0;
        snd_left          = '0;
        snd_right         = '0;
        repeat (4) @(posedge clk_sys);
        #1;
        rst = 1'b0;

        check_value("sd_cs_n", 1, sd_cs_n);
        check_value("sd_clk", 0, sd_clk);
        check_value("wb_cyc", 0, wb_cyc);
        check_value("wb_stb", 0, wb_stb);
        check_value("snd_pwm_l", 0, snd_pwm_l);
        check_value("snd_pwm_r", 0, snd_pwm_r);
        check_value("status", 0, status);
        finish_test("reset state");

        wait (downloading == 1'b0);  // Falls after the last ack
        wait (sd_cs_n == 1'b1);
        @(posedge clk_sys);
        #1;
        check_value("write count", ROM_BYTES, write_count);
        check_value("downloading", 0, downloading);
        check_value("sd_cs_n", 1, sd_cs_n);
        finish_test("ROM load under back-pressure");

        check_value("flash command seen", 1, cmd_seen);
        check_value("flash model errors", 0, flash_errors);
        finish_test("flash command and chip select");

        for (int i = 0; i < VIDEO_ROUNDS; i++) begin
            r = next_random();
            drive_video(1'b1, r[3:0]);
            @(posedge clk_sys);
            #1;
            check_video(1'b1, r[3:0]);
        end
        finish_test("native video mode");

        // Every scanline field and BIOS bit combination
        for (int f = 0; f < 16; f++) begin
            drive_video(1'b0, 4'(f));
            @(posedge clk_sys);
            #1;
            check_video(1'b0, 4'(f));
        end
        finish_test("scan-doubled mode and status");

        for (int n = 0; n < 3; n++) begin
            r         = next_random();
            snd_left  = r[15:0];
            r         = next_random();
            snd_right = r[15:0];
            if (snd_right == snd_left) begin
                snd_right = ~snd_left;
            end
            ones_l = 0;
            ones_r = 0;
            repeat (DAC_WINDOW) begin
                @(posedge clk_sys);
                #1;
                ones_l += snd_pwm_l;
                ones_r += snd_pwm_r;
            end
            check_density("snd_pwm_l", snd_left, ones_l);
            check_density("snd_pwm_r", snd_right, ones_r);
        end
        finish_test("DAC density");

        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, errors + flash_errors);
        if (tests_failed == 0 && errors + flash_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== zxdos_base.f ====
source/av_pkg.sv
source/load_pkg.sv
source/sigma_delta_dac.sv
source/spi_flash_reader.sv
source/rom_loader.sv
source/video_route.sv
source/zxdos_base.sv
verif/spi_flash_model.sv
verif/tb_zxdos_base.sv

// ==== Bender.yml ====
package:
  name: zxdos_base

sources:
  # Packages first, then the RTL bottom up
  - source/av_pkg.sv
  - source/load_pkg.sv
  - source/sigma_delta_dac.sv
  - source/spi_flash_reader.sv
  - source/rom_loader.sv
  - source/video_route.sv
  - source/zxdos_base.sv

  - target: simulation
    files:
      - verif/spi_flash_model.sv
      - verif/tb_zxdos_base.sv
